// File: rtl/msx_cart_pkg.sv
package msx_cart_pkg;

   // One captured CPU cycle, 27 bits.
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data;          // CPU write data.
      logic        rd_start;      // One-cycle read pulse.
      logic        wr_start;      // One-cycle write pulse.
      logic        slot;
   } cart_bus_t;

   // One memory request, 36 bits.
   typedef struct packed {
      logic [24:0] mem_addr;
      logic        sram_oe;       // Cycle goes to SRAM.
      logic        sram_we;
      logic        rd;
      logic [7:0]  wdata;
   } mem_req_t;

   // rom_size is counted in 8 KB pages.
   localparam int PAGE_BITS = 13;

   // Smallest SRAM mask, so small ROMs still see SRAM at bank 10h.
   localparam logic [7:0] SRAM_MASK_MIN = 8'h10;

   // Bank 0 comes up here in the alternative variant.
   localparam logic [7:0] BANK0_RESET_ALT = 8'h0f;

endpackage

// File: rtl/cpu_cycle_capture.sv
`timescale 1ns/1ps

module cpu_cycle_capture (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [15:0]              addr,
   input  logic [7:0]               d_from_cpu,
   input  logic                     rd,
   input  logic                     wr,
   input  logic                     cs,
   input  logic                     slot,
   output msx_cart_pkg::cart_bus_t  bus
);

   logic rd_act;
   logic wr_act;
   logic rd_prev;
   logic wr_prev;

   assign rd_act = rd & cs;   // Strobes only count while selected.
   assign wr_act = wr & cs;

   // Previous qualified levels, for edge detection.
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_prev <= 1'b0;
         wr_prev <= 1'b0;
      end else begin
         rd_prev <= rd_act;
         wr_prev <= wr_act;
      end
   end

   // Start pulses go high for the cycle after the first active sample.
   always_ff @(posedge clk) begin
      if (reset) begin
         bus.rd_start <= 1'b0;
         bus.wr_start <= 1'b0;
      end else begin
         bus.rd_start <= rd_act & ~rd_prev;
         bus.wr_start <= wr_act & ~wr_prev;
      end
   end

   // Payload travels with the pulses.
   always_ff @(posedge clk) begin
      bus.addr <= addr;
      bus.data <= d_from_cpu;
      bus.slot <= slot;
   end

endmodule

// File: rtl/ascii16_mapper.sv
`timescale 1ns/1ps

module ascii16_mapper (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [24:0]              rom_size,
   input  logic                     r_type,
   input  msx_cart_pkg::cart_bus_t  bus,
   input  logic                     sel,
   output logic [24:0]              mem_addr,
   output logic                     sram_oe,
   output logic                     sram_we
);

   import msx_cart_pkg::*;

   logic [7:0] bank0;
   logic [7:0] bank1;
   logic [7:0] page_count;
   logic [7:0] page_mask;
   logic [7:0] sram_mask;
   logic [7:0] bank_base;
   logic       bank_write;

   assign page_count = rom_size[PAGE_BITS +: 8];
   assign page_mask  = page_count - 8'd1;            // ROM page wrap.
   assign sram_mask  = (page_count > SRAM_MASK_MIN) ? page_count : SRAM_MASK_MIN;

   assign bank_write = sel & bus.wr_start;

   always_ff @(posedge clk) begin
      if (reset) begin
         bank0 <= r_type ? BANK0_RESET_ALT : 8'h00;
         bank1 <= 8'h00;
      end else if (bank_write) begin
         if (r_type) begin
            // Only bank 1 is writable, bit 4 picks SRAM or a small ROM page.
            if (bus.addr[15:12] == 4'b0111) begin
               if (bus.data[4]) begin
                  bank1 <= {5'b00010, bus.data[2:0]};
               end else begin
                  bank1 <= {3'b000, bus.data[4:0]};
               end
            end
         end else begin
            case (bus.addr[15:11])
               5'b01100: bank0 <= bus.data;       // 6000h-67FFh.
               5'b01110: bank1 <= bus.data;       // 7000h-77FFh.
               default: ;
            endcase
         end
      end
   end

   // 4000h-7FFFh uses bank 0, 8000h-BFFFh bank 1.
   assign bank_base = bus.addr[15] ? bank1 : bank0;

   always_comb begin
      sram_oe = sel & (|(bank_base & sram_mask));
      sram_we = sel & bus.wr_start & (|(bank1 & sram_mask)) &
                (bus.addr[15:14] == 2'b10);
   end

   always_comb begin
      if (sram_oe) begin
         mem_addr = {12'd0, bus.addr[12:0]};      // 8 KB SRAM window.
      end else begin
         mem_addr = {3'd0, bank_base & page_mask, bus.addr[13:0]};
      end
   end

endmodule

// File: rtl/cart_slot_mapper.sv
`timescale 1ns/1ps

module cart_slot_mapper (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [24:0]              rom_size,
   input  logic                     r_type,
   input  msx_cart_pkg::cart_bus_t  bus,
   output msx_cart_pkg::mem_req_t   req
);

   logic        start;
   logic [24:0] mem_addr_a;
   logic [24:0] mem_addr_b;
   logic        sram_oe_a;
   logic        sram_oe_b;
   logic        sram_we_a;
   logic        sram_we_b;

   assign start = bus.rd_start | bus.wr_start;

   ascii16_mapper ascii16_mapper_a (
      .clk      (clk),
      .reset    (reset),
      .rom_size (rom_size),
      .r_type   (r_type),
      .bus      (bus),
      .sel      (start & ~bus.slot),
      .mem_addr (mem_addr_a),
      .sram_oe  (sram_oe_a),
      .sram_we  (sram_we_a)
   );

   ascii16_mapper ascii16_mapper_b (
      .clk      (clk),
      .reset    (reset),
      .rom_size (rom_size),
      .r_type   (r_type),
      .bus      (bus),
      .sel      (start & bus.slot),
      .mem_addr (mem_addr_b),
      .sram_oe  (sram_oe_b),
      .sram_we  (sram_we_b)
   );

   always_comb begin
      req.mem_addr = bus.slot ? mem_addr_b : mem_addr_a;
      req.sram_oe  = bus.slot ? sram_oe_b  : sram_oe_a;
      req.sram_we  = bus.slot ? sram_we_b  : sram_we_a;
      req.rd       = bus.rd_start;
      req.wdata    = bus.data;
   end

endmodule

// File: rtl/cart_mem.sv
`timescale 1ns/1ps

module cart_mem #(
   parameter int ROM_ADDR_W  = 17,
   parameter int SRAM_ADDR_W = 13
) (
   input  logic                     clk,
   input  logic                     load_we,
   input  logic [ROM_ADDR_W-1:0]    load_addr,
   input  logic [7:0]               load_data,
   input  msx_cart_pkg::mem_req_t   req,
   output logic [7:0]               rdata,
   output logic                     rdata_valid
);

   localparam int ROM_DEPTH  = 2 ** ROM_ADDR_W;
   localparam int SRAM_DEPTH = 2 ** SRAM_ADDR_W;

   logic [7:0] rom  [ROM_DEPTH];
   logic [7:0] sram [SRAM_DEPTH];

   logic [ROM_ADDR_W-1:0]  rom_idx;
   logic [SRAM_ADDR_W-1:0] sram_idx;

   assign rom_idx  = req.mem_addr[ROM_ADDR_W-1:0];
   assign sram_idx = req.mem_addr[SRAM_ADDR_W-1:0];

   // ROM image comes in through the load port.
   always_ff @(posedge clk) begin
      if (load_we) begin
         rom[load_addr] <= load_data;
      end
   end

   always_ff @(posedge clk) begin
      if (req.sram_we) begin
         sram[sram_idx] <= req.wdata;
      end
   end

   // One cycle read, byte held until the next read.
   always_ff @(posedge clk) begin
      if (req.rd) begin
         if (req.sram_oe) begin
            rdata <= sram[sram_idx];
         end else begin
            rdata <= rom[rom_idx];
         end
      end
   end

   always_ff @(posedge clk) begin
      rdata_valid <= req.rd;   // Valid one cycle after the read strobe.
   end

endmodule

// File: rtl/cart_read_return.sv
`timescale 1ns/1ps

module cart_read_return (
   input  logic       clk,
   input  logic       reset,
   input  logic [7:0] rdata,
   input  logic       rdata_valid,
   output logic [7:0] d_to_cpu,
   output logic       rd_valid
);

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rdata_valid;   // One pulse per read.
      end
   end

   // Last byte stays on the bus until the next read.
   always_ff @(posedge clk) begin
      if (rdata_valid) begin
         d_to_cpu <= rdata;
      end
   end

endmodule

// File: rtl/msx_cart_top.sv
`timescale 1ns/1ps

module msx_cart_top #(
   parameter int ROM_ADDR_W  = 17,
   parameter int SRAM_ADDR_W = 13
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [15:0]           addr,
   input  logic [7:0]            d_from_cpu,
   input  logic                  rd,
   input  logic                  wr,
   input  logic                  cs,
   input  logic                  slot,
   input  logic [24:0]           rom_size,
   input  logic                  r_type,
   input  logic                  load_we,
   input  logic [ROM_ADDR_W-1:0] load_addr,
   input  logic [7:0]            load_data,
   output logic [7:0]            d_to_cpu,
   output logic                  rd_valid
);

   import msx_cart_pkg::*;

   cart_bus_t  bus;
   mem_req_t   req;
   logic [7:0] rdata;
   logic       rdata_valid;

   cpu_cycle_capture cpu_cycle_capture_inst (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .d_from_cpu (d_from_cpu),
      .rd         (rd),
      .wr         (wr),
      .cs         (cs),
      .slot       (slot),
      .bus        (bus)
   );

   cart_slot_mapper cart_slot_mapper_inst (
      .clk      (clk),
      .reset    (reset),
      .rom_size (rom_size),
      .r_type   (r_type),
      .bus      (bus),
      .req      (req)
   );

   cart_mem #(
      .ROM_ADDR_W  (ROM_ADDR_W),
      .SRAM_ADDR_W (SRAM_ADDR_W)
   ) cart_mem_inst (
      .clk         (clk),
      .load_we     (load_we),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .req         (req),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

   cart_read_return cart_read_return_inst (
      .clk         (clk),
      .reset       (reset),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .d_to_cpu    (d_to_cpu),
      .rd_valid    (rd_valid)
   );

endmodule

// File: dv/cart_checker.sv
`timescale 1ns/1ps

module cart_checker #(
   parameter int ROM_ADDR_W  = 17,
   parameter int SRAM_ADDR_W = 13
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [15:0]           addr,
   input  logic [7:0]            d_from_cpu,
   input  logic                  rd,
   input  logic                  wr,
   input  logic                  cs,
   input  logic                  slot,
   input  logic [24:0]           rom_size,
   input  logic                  r_type,
   input  logic                  load_we,
   input  logic [ROM_ADDR_W-1:0] load_addr,
   input  logic [7:0]            load_data,
   input  logic [7:0]            d_to_cpu,
   input  logic                  rd_valid,
   input  logic [2:0]            test_id,
   output int                    error_count,
   output int                    check_count,
   output int                    outstanding
);

   import msx_cart_pkg::*;

   localparam int ROM_DEPTH  = 2 ** ROM_ADDR_W;
   localparam int SRAM_DEPTH = 2 ** SRAM_ADDR_W;

   typedef struct packed {
      int         due;       // Cycle in which rd_valid must be seen.
      logic [7:0] data;
      logic       known;     // SRAM byte never written is not compared.
      logic [2:0] test_id;
   } read_exp_t;

   logic [7:0] rom_model  [ROM_DEPTH];
   logic [7:0] sram_model [SRAM_DEPTH];
   logic       sram_known [SRAM_DEPTH];
   logic [7:0] bank       [2][2];     // Indexed by slot, then bank.
   read_exp_t  pending_q  [$];
   int         cycle;
   int         errors;
   int         checks;
   logic       rd_prev;
   logic       wr_prev;

   initial begin
      for (int i = 0; i < SRAM_DEPTH; i++) begin
         sram_known[i] = 1'b0;
      end
      cycle       = 0;
      errors      = 0;
      checks      = 0;
      error_count = 0;
      check_count = 0;
      outstanding = 0;
   end

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "reset_values";
         3'd2:    return "plain_bank_switching";
         3'd3:    return "slot_independence";
         3'd4:    return "sram_access";
         3'd5:    return "alt_bank1_decoding";
         3'd6:    return "read_latency";
         default: return "setup";
      endcase
   endfunction

   function automatic logic [7:0] page_count();
      logic [24:0] pages;
      pages = rom_size >> PAGE_BITS;
      return pages[7:0];
   endfunction

   // SRAM is seen when the bank hits the mask, never below SRAM_MASK_MIN.
   function automatic logic in_sram(input logic [7:0] base);
      logic [7:0] mask;
      mask = (page_count() < SRAM_MASK_MIN) ? SRAM_MASK_MIN : page_count();
      return (base & mask) != 8'h00;
   endfunction

   task automatic apply_write(input logic s, input logic [15:0] a, input logic [7:0] d);
      int off;
      if (r_type) begin
         if (a[15:12] == 4'h7) begin
            bank[s][1] = d[4] ? (8'h10 | (d & 8'h07)) : (d & 8'h0f);
         end
      end else if (a >= 16'h6000 && a < 16'h6800) begin
         bank[s][0] = d;
      end else if (a >= 16'h7000 && a < 16'h7800) begin
         bank[s][1] = d;
      end
      if (in_sram(bank[s][1]) && a >= 16'h8000 && a < 16'hc000) begin
         off = a[12:0];
         off = off % SRAM_DEPTH;
         sram_model[off] = d;
         sram_known[off] = 1'b1;
      end
   endtask

   task automatic queue_read(input logic s, input logic [15:0] a);
      read_exp_t  e;
      logic [7:0] base;
      int         idx;
      base      = a[15] ? bank[s][1] : bank[s][0];
      e.due     = cycle + 3;                     // Capture, memory, return.
      e.test_id = test_id;
      if (in_sram(base)) begin
         idx     = a[12:0];
         idx     = idx % SRAM_DEPTH;
         e.data  = sram_model[idx];
         e.known = sram_known[idx];
      end else begin
         idx     = base & (page_count() - 8'd1);
         idx     = (idx * 16384 + a[13:0]) % ROM_DEPTH;   // 16 KB banks.
         e.data  = rom_model[idx];
         e.known = 1'b1;
      end
      pending_q.push_back(e);
   endtask

   task automatic check_return();
      read_exp_t e;
      if (rd_valid) begin
         if (pending_q.size() == 0) begin
            $display("Unexpected rd_valid at cycle %0d with no read outstanding", cycle);
            errors++;
         end else begin
            e = pending_q.pop_front();
            if (e.due != cycle) begin
               $display("rd_valid for a %s read came at cycle %0d but was due at cycle %0d",
                        test_name(e.test_id), cycle, e.due);
               errors++;
            end else if (e.known) begin
               checks++;
               if (d_to_cpu !== e.data) begin
                  $display("ERROR %s: expected %02h, actual %02h",
                           test_name(e.test_id), e.data, d_to_cpu);
                  errors++;
               end
            end
         end
      end
      while (pending_q.size() != 0) begin
         e = pending_q[0];
         if (e.due >= cycle) begin
            break;
         end
         void'(pending_q.pop_front());
         $display("Missing rd_valid for a %s read due at cycle %0d",
                  test_name(e.test_id), e.due);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (load_we) begin
         rom_model[load_addr] = load_data;
      end
      if (reset) begin
         for (int s = 0; s < 2; s++) begin
            bank[s][0] = r_type ? BANK0_RESET_ALT : 8'h00;
            bank[s][1] = 8'h00;
         end
         if (pending_q.size() != 0) begin
            $display("Reset arrived with %0d reads still outstanding", pending_q.size());
            errors++;
            pending_q.delete();
         end
         rd_prev = 1'b0;
         wr_prev = 1'b0;
      end else begin
         check_return();
         if (wr && cs && !wr_prev) begin
            apply_write(slot, addr, d_from_cpu);
         end
         if (rd && cs && !rd_prev) begin
            queue_read(slot, addr);
         end
         rd_prev = rd & cs;
         wr_prev = wr & cs;
      end
      error_count <= errors;
      check_count <= checks;
      outstanding <= pending_q.size();
   end

endmodule

// File: dv/tb_msx_cart.sv
`timescale 1ns/1ps

module tb_msx_cart;

   localparam int ROM_ADDR_W  = 17;
   localparam int SRAM_ADDR_W = 13;
   localparam int ROM_DEPTH   = 2 ** ROM_ADDR_W;
   localparam int DRAIN_LIMIT = 40;

   logic                  clk;
   logic                  reset;
   logic [15:0]           addr;
   logic [7:0]            d_from_cpu;
   logic                  rd;
   logic                  wr;
   logic                  cs;
   logic                  slot;
   logic [24:0]           rom_size;
   logic                  r_type;
   logic                  load_we;
   logic [ROM_ADDR_W-1:0] load_addr;
   logic [7:0]            load_data;
   logic [7:0]            d_to_cpu;
   logic                  rd_valid;
   logic [2:0]            test_id;
   int                    error_count;
   int                    check_count;
   int                    outstanding;
   int                    tb_errors;
   int unsigned           seed;

   msx_cart_top #(
      .ROM_ADDR_W  (ROM_ADDR_W),
      .SRAM_ADDR_W (SRAM_ADDR_W)
   ) msx_cart_top_inst (.*);

   cart_checker #(
      .ROM_ADDR_W  (ROM_ADDR_W),
      .SRAM_ADDR_W (SRAM_ADDR_W)
   ) cart_checker_inst (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic apply_reset(input logic variant);
      @(posedge clk);
      reset  <= 1'b1;
      r_type <= variant;   // Variant only changes under reset.
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic load_rom();
      for (int i = 0; i < ROM_DEPTH; i++) begin
         @(posedge clk);
         load_we   <= 1'b1;
         load_addr <= i;
         load_data <= $urandom;
      end
      @(posedge clk);
      load_we <= 1'b0;
   endtask

   task automatic cpu_access(input logic write, input logic s, input logic [15:0] a,
                             input logic [7:0] d, input int hold);
      @(posedge clk);
      addr       <= a;
      d_from_cpu <= d;
      slot       <= s;
      cs         <= 1'b1;
      rd         <= ~write;
      wr         <= write;
      repeat (hold) @(posedge clk);
      cs <= 1'b0;
      rd <= 1'b0;
      wr <= 1'b0;
   endtask

   task automatic cpu_read(input logic s, input logic [15:0] a);
      cpu_access(1'b0, s, a, 8'h00, 1 + $urandom % 3);
   endtask

   task automatic cpu_write(input logic s, input logic [15:0] a, input logic [7:0] d);
      cpu_access(1'b1, s, a, d, 1 + $urandom % 3);
   endtask

   function automatic logic [15:0] rand_addr(input logic [15:0] base, input int span);
      logic [15:0] off;
      off = $urandom % span;
      return base + off;
   endfunction

   task automatic wait_drain();
      int waited;
      waited = 0;
      @(posedge clk);
      while (outstanding != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (outstanding != 0) begin
         $display("Timeout: %0d reads never returned", outstanding);
         tb_errors++;
      end
   endtask

   task automatic reset_reads();
      test_id <= 3'd1;
      repeat (20) cpu_read($urandom % 2, rand_addr(16'h4000, 16'h8000));
      wait_drain();
   endtask

   initial begin : run
      logic [15:0] a;
      logic [7:0]  d;
      logic        s;
      seed       = 32'hc828_243e;
      d          = $urandom(seed);   // Seeds the generator once.
      reset      = 1'b1;
      r_type     = 1'b0;
      addr       = 16'h0000;
      d_from_cpu = 8'h00;
      rd         = 1'b0;
      wr         = 1'b0;
      cs         = 1'b0;
      slot       = 1'b0;
      rom_size   = ROM_DEPTH / 4;   // Four 8 KB pages in a larger array.
      load_we    = 1'b0;
      load_addr  = '0;
      load_data  = 8'h00;
      test_id    = 3'd0;
      tb_errors  = 0;

      apply_reset(1'b0);
      load_rom();
      reset_reads();

      test_id <= 3'd2;
      repeat (25) begin
         s = $urandom % 2;
         a = ($urandom % 2) ? rand_addr(16'h6000, 16'h800) : rand_addr(16'h7000, 16'h800);
         cpu_write(s, a, $urandom & 8'hef);   // High bits exercise the page mask.
         repeat (3) cpu_read(s, rand_addr(16'h4000, 16'h8000));
      end
      wait_drain();

      test_id <= 3'd3;
      repeat (20) begin
         s = $urandom % 2;
         cpu_write(s, 16'h6000, $urandom & 8'hef);
         cpu_write(s, 16'h7000, $urandom & 8'hef);
         repeat (2) cpu_read(~s, rand_addr(16'h4000, 16'h8000));
      end
      wait_drain();

      test_id <= 3'd4;
      repeat (12) begin
         s = $urandom % 2;
         a = rand_addr(16'h8000, 16'h4000);
         d = $urandom;
         cpu_write(s, 16'h7000, 8'h10 | ($urandom & 8'h0f));
         cpu_write(s, a, d);
         cpu_read(s, a);
         cpu_write(s, 16'h6000, 8'h10);
         cpu_read(s, 16'h4000 | (a & 16'h1fff));   // Same SRAM byte through bank 0.
         cpu_write(s, 16'h7000, $urandom & 8'h0f);
         cpu_write(s, a, ~d);                      // ROM bank, no store.
         cpu_read(s, a);
      end
      wait_drain();

      apply_reset(1'b1);
      reset_reads();

      test_id <= 3'd5;
      repeat (30) begin
         s = $urandom % 2;
         cpu_write(s, rand_addr(16'h6000, 16'h2000), $urandom);
         a = rand_addr(16'h8000, 16'h4000);
         cpu_write(s, a, $urandom);
         cpu_read(s, a);
         cpu_read(s, rand_addr(16'h4000, 16'h4000));
      end
      wait_drain();

      test_id <= 3'd6;
      repeat (40) cpu_access(1'b0, $urandom % 2, rand_addr(16'h4000, 16'h8000), 8'h00, 1);
      wait_drain();
      repeat (4) @(posedge clk);   // Room for a stray rd_valid to show up.

      if (check_count == 0) begin
         $display("The checker compared no read data");
         tb_errors++;
      end
      $display("Closing report: %0d checker errors, %0d testbench errors, %0d reads compared",
               error_count, tb_errors, check_count);
      if (error_count == 0 && tb_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: msx_cart.f
rtl/msx_cart_pkg.sv
rtl/cpu_cycle_capture.sv
rtl/ascii16_mapper.sv
rtl/cart_slot_mapper.sv
rtl/cart_mem.sv
rtl/cart_read_return.sv
rtl/msx_cart_top.sv
dv/cart_checker.sv
dv/tb_msx_cart.sv
